// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // start, 8 data, parity and stop bit times
  localparam int FRAME_BITS = 11;

  // one byte on the serial line
  typedef logic [7:0] byte_t;

  // index of the current bit inside a frame
  typedef logic [3:0] bit_cnt_t;

  // high byte on the line is {rd, addr}, low byte is data
  typedef struct packed {
    logic       rd;
    logic [6:0] addr;
    byte_t      data;
  } cmd_t;

  // one received frame
  typedef struct packed {
    byte_t data;
    logic  parity_ok;
  } rx_result_t;

  // command sequencer states
  typedef enum logic [1:0] {
    IDLE,
    SEND_HI,
    SEND_LO,
    WAIT_RX
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/uart_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  tx_start,
  input  wire uart_pkg::byte_t tx_byte,
  output logic                 tx,
  output logic                 tx_busy,
  output logic                 tx_done
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam uart_pkg::bit_cnt_t STOP_IDX = uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1);

  logic [CNT_W-1:0]                  clk_cnt;
  uart_pkg::bit_cnt_t                bit_cnt;
  logic [uart_pkg::FRAME_BITS-2:0]   shreg;
  logic                              bit_end;
  logic                              load;

  assign bit_end = tx_busy && (clk_cnt == BIT_LAST);
  assign tx_done = bit_end && (bit_cnt == STOP_IDX);

  // a new frame may follow directly on the last stop cycle
  assign load = tx_start && (!tx_busy || tx_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (load) begin
      // start bit goes out right away
      tx      <= 1'b0;
      tx_busy <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (tx_done) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
    end else if (bit_end) begin
      tx      <= shreg[0];
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
    end else if (tx_busy) begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // data LSB first, then odd parity, then stop
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    end else if (bit_end) begin
      shreg <= {1'b1, shreg[uart_pkg::FRAME_BITS-2:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_rx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   rx,
  output logic                  rx_done,
  output uart_pkg::rx_result_t  rx_res
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam uart_pkg::bit_cnt_t PAR_IDX  = uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 2);
  localparam uart_pkg::bit_cnt_t STOP_IDX = uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1);

  logic               rx_s1;
  logic               rx_s2;
  logic               rx_prev;
  logic               active;
  logic [CNT_W-1:0]   clk_cnt;
  uart_pkg::bit_cnt_t bit_cnt;
  uart_pkg::byte_t    shreg;
  logic               par_bit;
  logic               fall;
  logic               sample;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign fall = rx_prev && !rx_s2;

  // first sample lands half a bit in, then one per bit period
  assign sample = active &&
                  (clk_cnt == ((bit_cnt == '0) ? HALF_LAST : BIT_LAST));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (!active) begin
        if (fall) begin
          active  <= 1'b1;
          clk_cnt <= '0;
          bit_cnt <= '0;
        end
      end else if (sample) begin
        clk_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == '0 && rx_s2) begin
          // glitch, not a start bit
          active <= 1'b0;
        end
        if (bit_cnt == STOP_IDX) begin
          active  <= 1'b0;
          rx_done <= rx_s2;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  // data bits come in LSB first
  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_cnt != '0 && bit_cnt < PAR_IDX) begin
        shreg <= {rx_s2, shreg[7:1]};
      end
      if (bit_cnt == PAR_IDX) begin
        par_bit <= rx_s2;
      end
      if (bit_cnt == STOP_IDX) begin
        rx_res.data      <= shreg;
        // good odd parity leaves an odd count of ones
        rx_res.parity_ok <= ^{shreg, par_bit};
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_ctrl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire uart_pkg::cmd_t       cmd,
  input  wire                       cmd_vld,
  input  wire                       tx_busy,
  input  wire                       tx_done,
  input  wire                       rx_done,
  input  wire uart_pkg::rx_result_t rx_res,
  output logic                      cmd_rdy,
  output logic                      tx_start,
  output uart_pkg::byte_t           tx_byte,
  output uart_pkg::byte_t           read_data,
  output logic                      read_vld,
  output logic                      parity_err
);

  uart_pkg::ctrl_state_e state;
  uart_pkg::cmd_t        cmd_q;
  logic                  accept;
  logic                  reply_seen;
  logic                  rx_take;

  assign cmd_rdy = (state == uart_pkg::IDLE) && !tx_busy;
  assign accept  = cmd_vld && cmd_rdy;

  // high byte starts in the accept cycle, low byte on the first tx_done
  assign tx_start = accept || ((state == uart_pkg::SEND_HI) && tx_done);
  assign tx_byte  = (state == uart_pkg::IDLE) ? {cmd.rd, cmd.addr} : cmd_q.data;

  assign reply_seen = read_vld || parity_err;
  assign rx_take    = (state == uart_pkg::WAIT_RX) && rx_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::IDLE;
    end else begin
      case (state)
        uart_pkg::IDLE: begin
          if (accept) begin
            state <= uart_pkg::SEND_HI;
          end
        end
        uart_pkg::SEND_HI: begin
          if (tx_done) begin
            state <= uart_pkg::SEND_LO;
          end
        end
        uart_pkg::SEND_LO: begin
          if (tx_done) begin
            state <= cmd_q.rd ? uart_pkg::WAIT_RX : uart_pkg::IDLE;
          end
        end
        uart_pkg::WAIT_RX: begin
          // leave one cycle after the result pulse
          if (reply_seen) begin
            state <= uart_pkg::IDLE;
          end
        end
        default: begin
          state <= uart_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_vld   <= 1'b0;
      parity_err <= 1'b0;
    end else begin
      read_vld   <= rx_take && rx_res.parity_ok;
      parity_err <= rx_take && !rx_res.parity_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
    if (rx_take) begin
      read_data <= rx_res.data;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uart_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire uart_pkg::cmd_t  cmd,
  input  wire                  cmd_vld,
  output logic                 cmd_rdy,
  input  wire                  rx,
  output logic                 tx,
  output uart_pkg::byte_t      read_data,
  output logic                 read_vld,
  output logic                 parity_err
);

  logic                 tx_start;
  uart_pkg::byte_t      tx_byte;
  logic                 tx_busy;
  logic                 tx_done;
  logic                 rx_done;
  uart_pkg::rx_result_t rx_res;

  uart_cmd_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_vld    (cmd_vld),
    .tx_busy    (tx_busy),
    .tx_done    (tx_done),
    .rx_done    (rx_done),
    .rx_res     (rx_res),
    .cmd_rdy    (cmd_rdy),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

  uart_tx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  // receiver hunts for frames all the time
  uart_rx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_res  (rx_res)
  );

endmodule

`default_nettype wire

// File: tb/tb_uart_line.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_line #(
  parameter int CLKS_PER_BIT = 434
) (
  input  wire  clk,
  input  wire  tx,
  output logic rx
);

  // one frame as seen on tx
  typedef struct packed {
    uart_pkg::byte_t data;
    logic            par;
    logic            stop;
  } line_frame_t;

  line_frame_t frames[$];
  int          bad_starts = 0;

  initial begin
    rx = 1'b1;
  end

  // decode tx frames by sampling each bit near its middle
  initial begin : decode
    line_frame_t f;
    forever begin
      @(negedge tx);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (tx !== 1'b0) begin
        // start bit gone before mid-bit
        bad_starts++;
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          f.data[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        f.par = tx;
        repeat (CLKS_PER_BIT) @(negedge clk);
        f.stop = tx;
        // hand over away from the falling edge
        @(posedge clk);
        frames.push_back(f);
      end
    end
  end

  function automatic int frame_count();
    return frames.size();
  endfunction

  task automatic pop_frame(
    output uart_pkg::byte_t data,
    output logic            par,
    output logic            stop
  );
    line_frame_t f;
    f = frames.pop_front();
    data = f.data;
    par  = f.par;
    stop = f.stop;
  endtask

  // idle gap, then start, data LSB first, parity, stop
  task automatic send_reply(
    input uart_pkg::byte_t data,
    input logic            good_par,
    input int              gap_bits
  );
    logic [uart_pkg::FRAME_BITS-1:0] bits;
    bits = {1'b1, (good_par ? ~^data : ^data), data, 1'b0};
    rx = 1'b1;
    repeat (gap_bits * CLKS_PER_BIT) @(negedge clk);
    for (int i = 0; i < uart_pkg::FRAME_BITS; i++) begin
      rx = bits[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    rx = 1'b1;
  endtask

endmodule

`default_nettype wire

// File: tb/tb_uart_cmd.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_cmd;

  localparam int CLKS_PER_BIT   = 16;
  localparam int N_WRITES       = 6;
  localparam int N_READS        = 3;
  localparam int N_BAD_READS    = 2;
  localparam int N_CMDS         = N_WRITES + N_READS + N_BAD_READS + 1;
  localparam int TIMEOUT_CYCLES = N_CMDS * 40 * CLKS_PER_BIT + 500;
  localparam int WAIT_LIMIT     = 40 * CLKS_PER_BIT;
  localparam int INJECT_AT      = 5 * CLKS_PER_BIT;

  logic            clk;
  logic            rst_n;
  uart_pkg::cmd_t  cmd;
  logic            cmd_vld;
  logic            cmd_rdy;
  logic            rx;
  logic            tx;
  uart_pkg::byte_t read_data;
  logic            read_vld;
  logic            parity_err;

  int              errors     = 0;
  int              cycles     = 0;
  int              vld_pulses = 0;
  int              err_pulses = 0;
  logic            reply_d    = 1'b0;
  uart_pkg::byte_t exp_reply  = '0;
  integer          seed;

  uart_cmd_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .rx         (rx),
    .tx         (tx),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

  tb_uart_line #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_line (
    .clk (clk),
    .tx  (tx),
    .rx  (rx)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles, %0d errors so far",
               TIMEOUT_CYCLES, errors);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("FAIL %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // reply pulses, read data and the cmd_rdy return
  always @(negedge clk) begin
    if (rst_n) begin
      assert (!(read_vld && parity_err)) else begin
        errors++;
        $display("read_vld and parity_err were high in the same cycle");
      end
      if (read_vld) begin
        vld_pulses++;
        check_val("read_data", exp_reply, read_data);
      end
      if (parity_err) begin
        err_pulses++;
      end
      if (read_vld || parity_err) begin
        check_val("cmd_rdy during reply pulse", 0, cmd_rdy);
      end
      if (reply_d) begin
        check_val("cmd_rdy after reply pulse", 1, cmd_rdy);
      end
      reply_d = read_vld || parity_err;
    end
  end

  task automatic make_cmd(input logic rd, output uart_pkg::cmd_t c);
    logic [31:0] r;
    r    = $random(seed);
    c    = r[15:0];
    c.rd = rd;
  endtask

  task automatic issue_cmd(input uart_pkg::cmd_t c);
    @(negedge clk);
    cmd     = c;
    cmd_vld = 1'b1;
    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_ready(input logic inject, input uart_pkg::cmd_t other,
                            output int low_cycles);
    low_cycles = 0;
    while (cmd_rdy !== 1'b1 && low_cycles < WAIT_LIMIT) begin
      @(negedge clk);
      low_cycles++;
      // a command offered while busy must be ignored
      if (inject && low_cycles == INJECT_AT) begin
        cmd     = other;
        cmd_vld = 1'b1;
      end else begin
        cmd_vld = 1'b0;
      end
    end
    cmd_vld = 1'b0;
    if (cmd_rdy !== 1'b1) begin
      errors++;
      $display("cmd_rdy did not return high within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic wait_frames(input int n);
    int waited;
    waited = 0;
    while (u_line.frame_count() < n && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (u_line.frame_count() < n) begin
      errors++;
      $display("only %0d of %0d frames seen on tx", u_line.frame_count(), n);
    end
  endtask

  task automatic check_frame(input string name, input uart_pkg::byte_t exp);
    uart_pkg::byte_t d;
    logic            p;
    logic            s;
    if (u_line.frame_count() == 0) begin
      errors++;
      $display("no frame captured on tx for %s", name);
    end else begin
      u_line.pop_frame(d, p, s);
      check_val(name, exp, d);
      // odd parity over byte and parity bit
      check_val({name, " parity"}, 1, ^{d, p});
      check_val({name, " stop bit"}, 1, s);
    end
  endtask

  task automatic do_write(input logic inject);
    uart_pkg::cmd_t c;
    uart_pkg::cmd_t other;
    int             low;
    make_cmd(1'b0, c);
    other = c ^ 16'h5a5a;
    issue_cmd(c);
    wait_ready(inject, other, low);
    check_val("write cmd_rdy low cycles", 22 * CLKS_PER_BIT, low);
    check_val("write frame count", 2, u_line.frame_count());
    check_frame("write high byte", {c.rd, c.addr});
    check_frame("write low byte", c.data);
  endtask

  task automatic do_read(input logic good);
    uart_pkg::cmd_t  c;
    uart_pkg::byte_t reply;
    logic [31:0]     r;
    int              gap;
    int              vld0;
    int              err0;
    int              low;
    make_cmd(1'b1, c);
    r         = $random(seed);
    reply     = r[7:0];
    gap       = 1 + r[9:8];
    vld0      = vld_pulses;
    err0      = err_pulses;
    exp_reply = reply;
    issue_cmd(c);
    wait_frames(2);
    check_frame("read high byte", {c.rd, c.addr});
    check_frame("read low byte", c.data);
    u_line.send_reply(reply, good, gap);
    wait_ready(1'b0, c, low);
    check_val("read_vld pulses", good ? 1 : 0, vld_pulses - vld0);
    check_val("parity_err pulses", good ? 0 : 1, err_pulses - err0);
  endtask

  // reply with no read pending
  task automatic do_stray();
    uart_pkg::cmd_t c;
    logic [31:0]    r;
    int             vld0;
    int             err0;
    int             low;
    make_cmd(1'b0, c);
    r = $random(seed);
    issue_cmd(c);
    wait_ready(1'b0, c, low);
    check_frame("stray write high byte", {c.rd, c.addr});
    check_frame("stray write low byte", c.data);
    vld0 = vld_pulses;
    err0 = err_pulses;
    u_line.send_reply(r[7:0], 1'b1, 1 + r[9:8]);
    repeat (2 * CLKS_PER_BIT) @(negedge clk);
    check_val("stray reply read_vld pulses", 0, vld_pulses - vld0);
    check_val("stray reply parity_err pulses", 0, err_pulses - err0);
    check_val("cmd_rdy after stray reply", 1, cmd_rdy);
  endtask

  initial begin
    seed    = 32'h255;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_val("reset tx", 1, tx);
    check_val("reset cmd_rdy", 1, cmd_rdy);
    check_val("reset read_vld", 0, read_vld);
    check_val("reset parity_err", 0, parity_err);
    for (int i = 0; i < N_WRITES; i++) begin
      do_write(1'b1);
    end
    check_val("reply pulses before any read", 0, vld_pulses + err_pulses);
    for (int i = 0; i < N_READS; i++) begin
      do_read(1'b1);
    end
    for (int i = 0; i < N_BAD_READS; i++) begin
      do_read(1'b0);
    end
    do_stray();
    check_val("leftover tx frames", 0, u_line.frame_count());
    check_val("false start bits on tx", 0, u_line.bad_starts);
    $display("summary: %0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/uart_pkg.sv
rtl/uart_tx_frame.sv
rtl/uart_rx_frame.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_cmd_top.sv
tb/tb_uart_line.sv
tb/tb_uart_cmd.sv

// File: Bender.yml
package:
  name: uart_cmd

sources:
  # design, package first
  - rtl/uart_pkg.sv
  - rtl/uart_tx_frame.sv
  - rtl/uart_rx_frame.sv
  - rtl/uart_cmd_ctrl.sv
  - rtl/uart_cmd_top.sv

  # testbench
  - target: test
    files:
      - tb/tb_uart_line.sv
      - tb/tb_uart_cmd.sv
